// ==== Bender.yml ====
package:
  name: vchess_ctrl

sources:
  - vchess_pkg.sv
  - repdet_if.sv
  - axi4lite_write.sv
  - control.sv
  - repdet_table.sv
  - vchess_ctrl_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_vchess_ctrl.sv

// ==== axi4lite_write.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi4lite_write
   import vchess_pkg::*;
(
   input  wire         clk,
   input  wire         reset,
   input  wire  [39:0] axi_awaddr,
   input  wire  [2:0]  axi_awprot,
   input  wire         axi_awvalid,
   input  wire  word_t axi_wdata,
   input  wire  [3:0]  axi_wstrb,
   input  wire         axi_wvalid,
   input  wire         axi_bready,
   output logic        axi_awready,
   output logic        axi_wready,
   output logic        axi_bvalid,
   output logic [1:0]  axi_bresp,
   output logic [39:0] addr,
   output word_t       data,
   output logic        valid
);

   logic handshake;

   assign handshake = axi_awready && axi_awvalid && axi_wready && axi_wvalid;
   assign axi_bresp = 2'b00; // Always OKAY

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         axi_awready <= 1'b0;
         axi_wready <= 1'b0;
         axi_bvalid <= 1'b0;
         valid <= 1'b0;
      end
      else
      begin
         // One-cycle ready once both beats wait and no response is pending
         axi_awready <= axi_awvalid && axi_wvalid && !axi_awready && !axi_bvalid;
         axi_wready <= axi_awvalid && axi_wvalid && !axi_wready && !axi_bvalid;
         valid <= handshake;
         if (handshake)
            axi_bvalid <= 1'b1;
         else if (axi_bready)
            axi_bvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (handshake)
      begin
         addr <= axi_awaddr;
         data <= axi_wdata;
      end
   end

   a_valid_single: assert property (@(posedge clk) disable iff (reset)
      valid |=> !valid);

endmodule

`default_nettype wire

// ==== control.sv ====
`timescale 1ns/1ps
`default_nettype none

module control
   import vchess_pkg::*;
(
   input  wire                           clk,
   input  wire                           reset,
   input  wire  [39:0]                   wr_addr,
   input  wire  word_t                   wr_data,
   input  wire                           wr_valid,
   input  wire                           initial_mate,
   input  wire                           initial_stalemate,
   input  wire  signed [EVAL_WIDTH-1:0]  initial_eval,
   input  wire                           am_moves_ready,
   input  wire                           am_move_ready,
   input  wire  [MAX_POSITIONS_LOG2-1:0] am_move_count,
   input  wire  signed [EVAL_WIDTH-1:0]  am_eval_in,
   input  wire                           am_capture_in,
   input  wire                           am_white_in_check_in,
   input  wire                           am_black_in_check_in,
   input  wire  [63:0]                   am_white_is_attacking_in,
   input  wire  [63:0]                   am_black_is_attacking_in,
   input  wire  [39:0]                   axi_araddr,
   input  wire  [2:0]                    axi_arprot,
   input  wire                           axi_arvalid,
   input  wire                           axi_rready,
   output logic                          soft_reset,
   output logic                          am_new_board_valid,
   output logic                          am_clear_moves,
   output logic [MAX_POSITIONS_LOG2-1:0] am_move_index,
   output board_t                        am_new_board,
   output logic [3:0]                    am_castle_mask,
   output logic [3:0]                    am_en_passant_col,
   output logic                          am_white_to_move,
   output logic [HALF_MOVE_WIDTH-1:0]    am_half_move,
   output logic                          axi_arready,
   output word_t                         axi_rdata,
   output logic [1:0]                    axi_rresp,
   output logic                          axi_rvalid,
   repdet_if.ctrl                        rep
);

   logic      wr_in_map;
   logic      rd_in_map;
   reg_addr_e wr_reg;
   reg_addr_e rd_reg;
   logic [2:0] wr_rank;
   logic [2:0] rd_rank;
   word_t     rd_word;

   assign wr_in_map = (wr_addr[39:10] == '0);
   assign rd_in_map = (axi_araddr[39:10] == '0);
   assign wr_reg = reg_addr_e'(wr_addr[9:2]);
   assign rd_reg = reg_addr_e'(axi_araddr[9:2]);
   assign wr_rank = wr_addr[4:2];
   assign rd_rank = axi_araddr[4:2];

   assign axi_arready = 1'b1;
   assign axi_rresp = 2'b00;

   assign rep.query_board = am_new_board; // Root position is the query
   assign rep.query_castle_mask = am_castle_mask;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         am_new_board_valid <= 1'b0;
         am_clear_moves <= 1'b0;
         soft_reset <= 1'b0;
         rep.rep_wr_en <= 1'b0;
         rep.depth <= '0;
         am_move_index <= '0;
      end
      else
      begin
         am_new_board_valid <= 1'b0; // Strobes last one cycle
         am_clear_moves <= 1'b0;
         rep.rep_wr_en <= 1'b0;
         if (wr_valid && wr_in_map)
         begin
            case (wr_reg)
               CTRL:
               begin
                  am_new_board_valid <= wr_data[0];
                  am_clear_moves <= wr_data[1];
                  soft_reset <= wr_data[31];
               end
               MOVE_INDEX: am_move_index <= wr_data[MAX_POSITIONS_LOG2-1:0];
               REP_DEPTH: rep.depth <= wr_data[REPDET_WIDTH-1:0];
               REP_WRITE: rep.rep_wr_en <= wr_data[31];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_valid && wr_in_map)
      begin
         case (wr_reg)
            ROOT_FLAGS: {am_white_to_move, am_castle_mask, am_en_passant_col} <= wr_data[8:0];
            HALF_MOVE: am_half_move <= wr_data[HALF_MOVE_WIDTH-1:0];
            BOARD_R0, BOARD_R1, BOARD_R2, BOARD_R3,
            BOARD_R4, BOARD_R5, BOARD_R6, BOARD_R7:
               am_new_board[wr_rank * SIDE_WIDTH +: SIDE_WIDTH] <= wr_data;
            REP_CASTLE: rep.rep_castle_mask <= wr_data[3:0];
            REP_WRITE: rep.rep_wr_addr <= wr_data[REPDET_WIDTH-1:0];
            REP_BOARD_R0, REP_BOARD_R1, REP_BOARD_R2, REP_BOARD_R3,
            REP_BOARD_R4, REP_BOARD_R5, REP_BOARD_R6, REP_BOARD_R7:
               rep.rep_board[wr_rank * SIDE_WIDTH +: SIDE_WIDTH] <= wr_data;
            default: ;
         endcase
      end
   end

   always_comb
   begin
      rd_word = '0;
      if (rd_in_map)
      begin
         case (rd_reg)
            CTRL: rd_word = {soft_reset, 24'b0, rep.thrice_rep, initial_mate, initial_stalemate,
                             am_move_ready, am_moves_ready, am_clear_moves, am_new_board_valid};
            MOVE_INDEX: rd_word = word_t'(am_move_index);
            ROOT_FLAGS: rd_word = {23'b0, am_white_to_move, am_castle_mask, am_en_passant_col};
            HALF_MOVE: rd_word = word_t'(am_half_move);
            BOARD_R0, BOARD_R1, BOARD_R2, BOARD_R3,
            BOARD_R4, BOARD_R5, BOARD_R6, BOARD_R7:
               rd_word = am_new_board[rd_rank * SIDE_WIDTH +: SIDE_WIDTH];
            REP_DEPTH: rd_word = word_t'(rep.depth);
            REP_CASTLE: rd_word = {28'b0, rep.rep_castle_mask};
            REP_WRITE: rd_word = {rep.rep_wr_en, 27'b0, rep.rep_wr_addr};
            REP_BOARD_R0, REP_BOARD_R1, REP_BOARD_R2, REP_BOARD_R3,
            REP_BOARD_R4, REP_BOARD_R5, REP_BOARD_R6, REP_BOARD_R7:
               rd_word = rep.rep_board[rd_rank * SIDE_WIDTH +: SIDE_WIDTH];
            WHITE_ATK_LO: rd_word = am_white_is_attacking_in[31:0];
            WHITE_ATK_HI: rd_word = am_white_is_attacking_in[63:32];
            BLACK_ATK_LO: rd_word = am_black_is_attacking_in[31:0];
            BLACK_ATK_HI: rd_word = am_black_is_attacking_in[63:32];
            MOVE_FLAGS: rd_word = {29'b0, am_black_in_check_in, am_white_in_check_in,
                                   am_capture_in};
            EVAL: rd_word = {{(32 - EVAL_WIDTH){am_eval_in[EVAL_WIDTH-1]}}, am_eval_in};
            MOVE_COUNT: rd_word = word_t'(am_move_count);
            ROOT_EVAL: rd_word = {{(32 - EVAL_WIDTH){initial_eval[EVAL_WIDTH-1]}}, initial_eval};
            default: rd_word = '0;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         axi_rvalid <= 1'b0;
      else if (axi_arvalid)
         axi_rvalid <= 1'b1; // New request wins over a pending one
      else if (axi_rready)
         axi_rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (axi_arvalid)
         axi_rdata <= rd_word;
   end

   a_rvalid_after_arvalid: assert property (@(posedge clk) disable iff (reset)
      $rose(axi_rvalid) |-> $past(axi_arvalid) && !$isunknown(axi_rdata));

endmodule

`default_nettype wire

// ==== flist.f ====
vchess_pkg.sv
repdet_if.sv
axi4lite_write.sv
control.sv
repdet_table.sv
vchess_ctrl_top.sv
tb_clock_gen.sv
tb_vchess_ctrl.sv

// ==== repdet_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface repdet_if
   import vchess_pkg::*;
   ();

   board_t                  rep_board; // Staged history entry
   logic [3:0]              rep_castle_mask;
   logic [REPDET_WIDTH-1:0] rep_wr_addr;
   logic                    rep_wr_en;
   logic [REPDET_WIDTH-1:0] depth; // Entries below this count
   board_t                  query_board;
   logic [3:0]              query_castle_mask;
   logic                    thrice_rep;

   modport ctrl (
      output rep_board, rep_castle_mask, rep_wr_addr, rep_wr_en, depth,
      output query_board, query_castle_mask,
      input  thrice_rep
   );

   modport tbl (
      input  rep_board, rep_castle_mask, rep_wr_addr, rep_wr_en, depth,
      input  query_board, query_castle_mask,
      output thrice_rep
   );

endinterface

`default_nettype wire

// ==== repdet_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module repdet_table
   import vchess_pkg::*;
(
   input wire    clk,
   input wire    reset,
   repdet_if.tbl rep
);

   board_t                  hist_board [REPDET_DEPTH];
   logic [3:0]              hist_castle [REPDET_DEPTH];
   logic [REPDET_DEPTH-1:0] hist_valid;
   logic [REPDET_WIDTH:0]   hit_count; // Up to REPDET_DEPTH matches

   always_ff @(posedge clk)
   begin
      if (rep.rep_wr_en)
      begin
         hist_board[rep.rep_wr_addr] <= rep.rep_board;
         hist_castle[rep.rep_wr_addr] <= rep.rep_castle_mask;
      end
   end

   // Parallel compare of every live entry against the root position
   always_comb
   begin
      hit_count = '0;
      for (int i = 0; i < REPDET_DEPTH; i++)
      begin
         if (hist_valid[i] && (i < rep.depth) && (hist_board[i] == rep.query_board) &&
             (hist_castle[i] == rep.query_castle_mask))
            hit_count = hit_count + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         hist_valid <= '0;
         rep.thrice_rep <= 1'b0;
      end
      else
      begin
         if (rep.rep_wr_en)
            hist_valid[rep.rep_wr_addr] <= 1'b1;
         rep.thrice_rep <= (hit_count >= 2); // Plus the current position
      end
   end

   a_wr_addr_in_range: assert property (@(posedge clk) disable iff (reset)
      rep.rep_wr_en |-> !$isunknown(rep.rep_wr_addr) && (rep.rep_wr_addr < REPDET_DEPTH));

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
   output logic clk,
   output logic reset
);

   localparam int PERIOD_NS = 20;
   localparam int RESET_CYCLES = 10;

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0; // Released on a falling edge
   end

endmodule

`default_nettype wire

// ==== tb_vchess_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vchess_ctrl
   import vchess_pkg::*;
();

   typedef enum {OP_WRITE, OP_READ, OP_PULSE, OP_SOFT, OP_REP, OP_BOARD, OP_PORT} op_e;

   typedef struct {
      op_e        op;
      logic [7:0] addr;
      word_t      data;
      word_t      exp;
   } entry_t;

   logic clk;
   logic reset;
   logic [39:0] ctrl0_axi_araddr, ctrl0_axi_awaddr;
   logic [2:0] ctrl0_axi_arprot, ctrl0_axi_awprot;
   logic ctrl0_axi_arvalid, ctrl0_axi_awvalid, ctrl0_axi_wvalid;
   logic ctrl0_axi_bready, ctrl0_axi_rready;
   word_t ctrl0_axi_wdata, ctrl0_axi_rdata;
   logic [3:0] ctrl0_axi_wstrb;
   logic ctrl0_axi_arready, ctrl0_axi_awready, ctrl0_axi_wready;
   logic ctrl0_axi_bvalid, ctrl0_axi_rvalid;
   logic [1:0] ctrl0_axi_bresp, ctrl0_axi_rresp;
   logic soft_reset, am_new_board_valid, am_clear_moves, am_white_to_move, thrice_rep;
   logic [MAX_POSITIONS_LOG2-1:0] am_move_index, am_move_count;
   board_t am_new_board;
   logic [3:0] am_castle_mask, am_en_passant_col;
   logic [HALF_MOVE_WIDTH-1:0] am_half_move;
   logic initial_mate, initial_stalemate, am_moves_ready, am_move_ready;
   logic signed [EVAL_WIDTH-1:0] initial_eval, am_eval_in;
   logic am_capture_in, am_white_in_check_in, am_black_in_check_in;
   logic [63:0] am_white_is_attacking_in, am_black_is_attacking_in;

   entry_t stim[$];
   board_t exp_board;
   int     cycle_count = 0;
   int     cycle_limit = 100; // Raised once the table is built

   tb_clock_gen u_clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   vchess_ctrl_top u_vchess_ctrl_top (.*);

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t act, input word_t exp);
      if (act !== exp)
         abort_run($sformatf("FAIL %0t %s expected %h actual %h", $time, name, exp, act));
   endtask

   task automatic check_board(input string name, input board_t act, input board_t exp);
      if (act !== exp)
         abort_run($sformatf("FAIL %0t %s expected %h actual %h", $time, name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic act, input logic exp);
      if (act !== exp)
         abort_run($sformatf("FAIL %0t %s expected %b actual %b", $time, name, exp, act));
   endtask

   // Root position outputs that mirror a register
   task automatic verify_root_ports(input logic [7:0] addr, input word_t exp);
      case (addr)
         MOVE_INDEX: check_word("am_move_index", word_t'(am_move_index), exp);
         ROOT_FLAGS:
         begin
            check_bit("am_white_to_move", am_white_to_move, exp[8]);
            check_word("am_castle_mask", word_t'(am_castle_mask), word_t'(exp[7:4]));
            check_word("am_en_passant_col", word_t'(am_en_passant_col), word_t'(exp[3:0]));
         end
         HALF_MOVE: check_word("am_half_move", word_t'(am_half_move), exp);
         default: abort_run("no output port belongs to this stimulus address");
      endcase
   endtask

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count > cycle_limit)
         abort_run($sformatf("timeout after %0d cycles, the DUT stopped responding",
                             cycle_count));
   end

   task automatic axi_write(input logic [7:0] addr, input word_t data, input logic bready);
      @(negedge clk);
      ctrl0_axi_awaddr = {30'b0, addr, 2'b00};
      ctrl0_axi_wdata = data;
      ctrl0_axi_awvalid = 1'b1;
      ctrl0_axi_wvalid = 1'b1;
      ctrl0_axi_bready = bready;
      @(negedge clk);
      while (!(ctrl0_axi_awready && ctrl0_axi_wready))
         @(negedge clk);
      @(negedge clk); // Handshake taken on the edge just passed
      ctrl0_axi_awvalid = 1'b0;
      ctrl0_axi_wvalid = 1'b0;
      while (!ctrl0_axi_bvalid)
         @(negedge clk);
      check_word("ctrl0_axi_bresp", word_t'(ctrl0_axi_bresp), '0);
   endtask

   task automatic axi_read(input logic [7:0] addr, input word_t exp);
      @(negedge clk);
      ctrl0_axi_araddr = {30'b0, addr, 2'b00};
      ctrl0_axi_arvalid = 1'b1;
      @(negedge clk);
      ctrl0_axi_arvalid = 1'b0;
      while (!ctrl0_axi_rvalid)
         @(negedge clk);
      check_bit("ctrl0_axi_arready", ctrl0_axi_arready, 1'b1);
      check_word($sformatf("ctrl0_axi_rdata at word %02h", addr), ctrl0_axi_rdata, exp);
      check_word("ctrl0_axi_rresp", word_t'(ctrl0_axi_rresp), '0);
   endtask

   task automatic add_entry(input op_e op, input logic [7:0] addr, input word_t data,
                            input word_t exp);
      stim.push_back(entry_t'{op, addr, data, exp});
   endtask

   // Write, then read back only the implemented field bits
   task automatic add_rw(input logic [7:0] addr, input word_t data, input word_t mask);
      add_entry(OP_WRITE, addr, data, '0);
      add_entry(OP_READ, addr, '0, data & mask);
   endtask

   task automatic add_rep(input logic [7:0] addr, input word_t data, input logic exp);
      add_entry(OP_WRITE, addr, data, '0);
      add_entry(OP_REP, 8'h00, '0, word_t'(exp));
   endtask

   task automatic build_table();
      word_t rank [8];
      word_t flags;
      word_t move_index;
      word_t half_move;
      word_t ctrl_base;
      flags = $urandom;
      move_index = $urandom;
      half_move = $urandom;
      ctrl_base = {26'b0, initial_mate, initial_stalemate, am_move_ready, am_moves_ready,
                   2'b00};
      add_rw(MOVE_INDEX, move_index, 32'hff);
      add_entry(OP_PORT, MOVE_INDEX, '0, move_index & 32'hff);
      add_rw(ROOT_FLAGS, flags, 32'h1ff);
      add_entry(OP_PORT, ROOT_FLAGS, '0, flags & 32'h1ff);
      add_rw(HALF_MOVE, half_move, 32'hff);
      add_entry(OP_PORT, HALF_MOVE, '0, half_move & 32'hff);
      add_rw(REP_DEPTH, $urandom, 32'hf);
      add_rw(REP_CASTLE, $urandom, 32'hf);
      for (int r = 0; r < 8; r++)
      begin
         rank[r] = $urandom;
         exp_board[r * SIDE_WIDTH +: SIDE_WIDTH] = rank[r];
         add_rw(8'(BOARD_R0 + r), rank[r], 32'hffff_ffff);
      end
      add_entry(OP_BOARD, 8'h00, '0, '0);
      add_entry(OP_PULSE, CTRL, 32'h3, '0);
      add_entry(OP_WRITE, CTRL, 32'h8000_0000, '0);
      add_entry(OP_SOFT, 8'h00, '0, 32'd1);
      add_entry(OP_READ, CTRL, '0, ctrl_base | 32'h8000_0000);
      add_entry(OP_WRITE, CTRL, '0, '0);
      add_entry(OP_SOFT, 8'h00, '0, 32'd0);
      add_entry(OP_READ, CTRL, '0, ctrl_base);
      add_entry(OP_READ, WHITE_ATK_LO, '0, am_white_is_attacking_in[31:0]);
      add_entry(OP_READ, WHITE_ATK_HI, '0, am_white_is_attacking_in[63:32]);
      add_entry(OP_READ, BLACK_ATK_LO, '0, am_black_is_attacking_in[31:0]);
      add_entry(OP_READ, BLACK_ATK_HI, '0, am_black_is_attacking_in[63:32]);
      add_entry(OP_READ, MOVE_FLAGS, '0, {29'b0, am_black_in_check_in, am_white_in_check_in,
                                          am_capture_in});
      add_entry(OP_READ, EVAL, '0, {{8{am_eval_in[23]}}, am_eval_in});
      add_entry(OP_READ, MOVE_COUNT, '0, {24'b0, am_move_count});
      add_entry(OP_READ, ROOT_EVAL, '0, {{8{initial_eval[23]}}, initial_eval});
      add_entry(OP_READ, 8'h40, '0, '0);
      add_entry(OP_READ, 8'd133, '0, '0);
      // Same position into history entries 0 and 1
      add_entry(OP_WRITE, REP_CASTLE, {28'b0, flags[7:4]}, '0);
      for (int r = 0; r < 8; r++)
         add_entry(OP_WRITE, 8'(REP_BOARD_R0 + r), rank[r], '0);
      add_entry(OP_WRITE, REP_WRITE, 32'h8000_0000, '0);
      add_entry(OP_WRITE, REP_WRITE, 32'h8000_0001, '0);
      add_rep(REP_DEPTH, 32'd2, 1'b1);
      add_rep(REP_DEPTH, 32'd1, 1'b0);
      add_rep(REP_DEPTH, 32'd2, 1'b1);
      add_rep(ROOT_FLAGS, flags ^ 32'h10, 1'b0); // Castle mask differs
      add_rep(ROOT_FLAGS, flags, 1'b1);
      add_entry(OP_WRITE, REP_WRITE, 32'h8000_0003, '0);
      add_entry(OP_WRITE, REP_WRITE, 32'h8000_0004, '0);
      add_rep(REP_DEPTH, 32'd1, 1'b0); // Entries 1, 3 and 4 out of range
      add_rep(REP_DEPTH, 32'd5, 1'b1);
   endtask

   initial
   begin
      word_t       rnd;
      word_t       held_data;
      word_t       next_data;
      ctrl0_axi_araddr = '0;
      ctrl0_axi_awaddr = '0;
      ctrl0_axi_arprot = '0;
      ctrl0_axi_awprot = '0;
      ctrl0_axi_arvalid = 1'b0;
      ctrl0_axi_awvalid = 1'b0;
      ctrl0_axi_wvalid = 1'b0;
      ctrl0_axi_bready = 1'b0;
      ctrl0_axi_rready = 1'b1;
      ctrl0_axi_wdata = '0;
      ctrl0_axi_wstrb = 4'hf;
      {initial_mate, initial_stalemate, am_moves_ready, am_move_ready} = '0;
      {am_capture_in, am_white_in_check_in, am_black_in_check_in} = '0;
      {initial_eval, am_eval_in, am_move_count} = '0;
      am_white_is_attacking_in = '0;
      am_black_is_attacking_in = '0;
      void'($urandom(32'hf687));
      @(negedge clk);
      rnd = $urandom;
      {initial_mate, initial_stalemate, am_moves_ready, am_move_ready} = rnd[3:0];
      {am_capture_in, am_white_in_check_in, am_black_in_check_in} = rnd[6:4];
      am_move_count = rnd[15:8];
      rnd = $urandom;
      initial_eval = rnd[23:0];
      rnd = $urandom;
      am_eval_in = {1'b1, rnd[22:0]}; // Negative, so the sign extension shows
      am_white_is_attacking_in = {$urandom, $urandom};
      am_black_is_attacking_in = {$urandom, $urandom};
      build_table();
      cycle_limit = 40 * (stim.size() + 5) + 100;
      while (reset)
         @(negedge clk);
      check_bit("ctrl0_axi_bvalid", ctrl0_axi_bvalid, 1'b0);
      check_bit("ctrl0_axi_rvalid", ctrl0_axi_rvalid, 1'b0);
      check_bit("soft_reset", soft_reset, 1'b0);
      check_bit("thrice_rep", thrice_rep, 1'b0);
      foreach (stim[i])
      begin
         case (stim[i].op)
            OP_WRITE: axi_write(stim[i].addr, stim[i].data, 1'b1);
            OP_READ: axi_read(stim[i].addr, stim[i].exp);
            OP_PULSE:
            begin
               axi_write(stim[i].addr, stim[i].data, 1'b1);
               @(negedge clk);
               check_bit("am_new_board_valid", am_new_board_valid, stim[i].data[0]);
               check_bit("am_clear_moves", am_clear_moves, stim[i].data[1]);
               @(negedge clk);
               check_bit("am_new_board_valid", am_new_board_valid, 1'b0);
               check_bit("am_clear_moves", am_clear_moves, 1'b0);
            end
            OP_SOFT:
            begin
               @(negedge clk);
               check_bit("soft_reset", soft_reset, stim[i].exp[0]);
            end
            OP_REP:
            begin
               repeat (2) @(negedge clk); // Register update, then the registered flag
               check_bit("thrice_rep", thrice_rep, stim[i].exp[0]);
            end
            OP_BOARD:
            begin
               @(negedge clk);
               check_board("am_new_board", am_new_board, exp_board);
            end
            OP_PORT: verify_root_ports(stim[i].addr, stim[i].exp);
            default: abort_run("unknown operation in the stimulus table");
         endcase
      end
      // Read served while the B response waits, next write held off
      held_data = $urandom;
      next_data = $urandom;
      axi_write(HALF_MOVE, held_data, 1'b0);
      axi_read(HALF_MOVE, held_data & 32'hff);
      @(negedge clk);
      ctrl0_axi_awaddr = {30'b0, 8'(MOVE_INDEX), 2'b00};
      ctrl0_axi_wdata = next_data;
      ctrl0_axi_awvalid = 1'b1;
      ctrl0_axi_wvalid = 1'b1;
      repeat (3)
      begin
         @(negedge clk);
         check_bit("ctrl0_axi_awready", ctrl0_axi_awready, 1'b0);
         check_bit("ctrl0_axi_wready", ctrl0_axi_wready, 1'b0);
         check_bit("ctrl0_axi_bvalid", ctrl0_axi_bvalid, 1'b1);
      end
      ctrl0_axi_bready = 1'b1;
      axi_write(MOVE_INDEX, next_data, 1'b1);
      axi_read(MOVE_INDEX, next_data & 32'hff);
      axi_read(HALF_MOVE, held_data & 32'hff);
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vchess_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vchess_ctrl_top
   import vchess_pkg::*;
(
   input  wire                           clk,
   input  wire                           reset,
   input  wire  [39:0]                   ctrl0_axi_araddr,
   input  wire  [2:0]                    ctrl0_axi_arprot,
   input  wire                           ctrl0_axi_arvalid,
   input  wire  [39:0]                   ctrl0_axi_awaddr,
   input  wire  [2:0]                    ctrl0_axi_awprot,
   input  wire                           ctrl0_axi_awvalid,
   input  wire                           ctrl0_axi_bready,
   input  wire                           ctrl0_axi_rready,
   input  wire  word_t                   ctrl0_axi_wdata,
   input  wire  [3:0]                    ctrl0_axi_wstrb,
   input  wire                           ctrl0_axi_wvalid,
   output logic                          ctrl0_axi_arready,
   output logic                          ctrl0_axi_awready,
   output logic [1:0]                    ctrl0_axi_bresp,
   output logic                          ctrl0_axi_bvalid,
   output word_t                         ctrl0_axi_rdata,
   output logic [1:0]                    ctrl0_axi_rresp,
   output logic                          ctrl0_axi_rvalid,
   output logic                          ctrl0_axi_wready,
   output logic                          soft_reset,
   output logic                          am_new_board_valid,
   output logic                          am_clear_moves,
   output logic [MAX_POSITIONS_LOG2-1:0] am_move_index,
   output board_t                        am_new_board,
   output logic [3:0]                    am_castle_mask,
   output logic [3:0]                    am_en_passant_col,
   output logic                          am_white_to_move,
   output logic [HALF_MOVE_WIDTH-1:0]    am_half_move,
   input  wire                           initial_mate,
   input  wire                           initial_stalemate,
   input  wire  signed [EVAL_WIDTH-1:0]  initial_eval,
   input  wire                           am_moves_ready,
   input  wire                           am_move_ready,
   input  wire  [MAX_POSITIONS_LOG2-1:0] am_move_count,
   input  wire  signed [EVAL_WIDTH-1:0]  am_eval_in,
   input  wire                           am_capture_in,
   input  wire                           am_white_in_check_in,
   input  wire                           am_black_in_check_in,
   input  wire  [63:0]                   am_white_is_attacking_in,
   input  wire  [63:0]                   am_black_is_attacking_in,
   output logic                          thrice_rep
);

   wire [39:0] wr_addr;
   word_t      wr_data;
   wire        wr_valid;

   repdet_if rep_bus ();

   assign thrice_rep = rep_bus.thrice_rep;

   axi4lite_write u_axi4lite_write (
      .clk         (clk),
      .reset       (reset),
      .axi_awaddr  (ctrl0_axi_awaddr),
      .axi_awprot  (ctrl0_axi_awprot),
      .axi_awvalid (ctrl0_axi_awvalid),
      .axi_wdata   (ctrl0_axi_wdata),
      .axi_wstrb   (ctrl0_axi_wstrb),
      .axi_wvalid  (ctrl0_axi_wvalid),
      .axi_bready  (ctrl0_axi_bready),
      .axi_awready (ctrl0_axi_awready),
      .axi_wready  (ctrl0_axi_wready),
      .axi_bvalid  (ctrl0_axi_bvalid),
      .axi_bresp   (ctrl0_axi_bresp),
      .addr        (wr_addr),
      .data        (wr_data),
      .valid       (wr_valid)
   );

   control u_control (
      .clk                      (clk),
      .reset                    (reset),
      .wr_addr                  (wr_addr),
      .wr_data                  (wr_data),
      .wr_valid                 (wr_valid),
      .initial_mate             (initial_mate),
      .initial_stalemate        (initial_stalemate),
      .initial_eval             (initial_eval),
      .am_moves_ready           (am_moves_ready),
      .am_move_ready            (am_move_ready),
      .am_move_count            (am_move_count),
      .am_eval_in               (am_eval_in),
      .am_capture_in            (am_capture_in),
      .am_white_in_check_in     (am_white_in_check_in),
      .am_black_in_check_in     (am_black_in_check_in),
      .am_white_is_attacking_in (am_white_is_attacking_in),
      .am_black_is_attacking_in (am_black_is_attacking_in),
      .axi_araddr               (ctrl0_axi_araddr),
      .axi_arprot               (ctrl0_axi_arprot),
      .axi_arvalid              (ctrl0_axi_arvalid),
      .axi_rready               (ctrl0_axi_rready),
      .soft_reset               (soft_reset),
      .am_new_board_valid       (am_new_board_valid),
      .am_clear_moves           (am_clear_moves),
      .am_move_index            (am_move_index),
      .am_new_board             (am_new_board),
      .am_castle_mask           (am_castle_mask),
      .am_en_passant_col        (am_en_passant_col),
      .am_white_to_move         (am_white_to_move),
      .am_half_move             (am_half_move),
      .axi_arready              (ctrl0_axi_arready),
      .axi_rdata                (ctrl0_axi_rdata),
      .axi_rresp                (ctrl0_axi_rresp),
      .axi_rvalid               (ctrl0_axi_rvalid),
      .rep                      (rep_bus)
   );

   repdet_table u_repdet_table (
      .clk   (clk),
      .reset (reset),
      .rep   (rep_bus)
   );

endmodule

`default_nettype wire

// ==== vchess_pkg.sv ====
`default_nettype none

package vchess_pkg;

   localparam int SIDE_WIDTH = 32; // 8 squares of 4 bits
   localparam int BOARD_WIDTH = 8 * SIDE_WIDTH;
   localparam int REPDET_WIDTH = 4;
   localparam int REPDET_DEPTH = 16;
   localparam int HALF_MOVE_WIDTH = 8;
   localparam int EVAL_WIDTH = 24; // Signed
   localparam int MAX_POSITIONS_LOG2 = 8;

   typedef logic [BOARD_WIDTH-1:0] board_t;
   typedef logic [31:0] word_t;

   // Word addresses, byte address bits 9:2
   typedef enum logic [7:0] {
      CTRL         = 8'h00,
      MOVE_INDEX   = 8'h01,
      ROOT_FLAGS   = 8'h02,
      HALF_MOVE    = 8'h03,
      BOARD_R0     = 8'h08,
      BOARD_R1     = 8'h09,
      BOARD_R2     = 8'h0a,
      BOARD_R3     = 8'h0b,
      BOARD_R4     = 8'h0c,
      BOARD_R5     = 8'h0d,
      BOARD_R6     = 8'h0e,
      BOARD_R7     = 8'h0f,
      REP_DEPTH    = 8'h10,
      REP_CASTLE   = 8'h11,
      REP_WRITE    = 8'h12,
      REP_BOARD_R0 = 8'h18,
      REP_BOARD_R1 = 8'h19,
      REP_BOARD_R2 = 8'h1a,
      REP_BOARD_R3 = 8'h1b,
      REP_BOARD_R4 = 8'h1c,
      REP_BOARD_R5 = 8'h1d,
      REP_BOARD_R6 = 8'h1e,
      REP_BOARD_R7 = 8'h1f,
      WHITE_ATK_LO = 8'd128,
      WHITE_ATK_HI = 8'd129,
      BLACK_ATK_LO = 8'd130,
      BLACK_ATK_HI = 8'd131,
      MOVE_FLAGS   = 8'd132,
      EVAL         = 8'd134,
      MOVE_COUNT   = 8'd135,
      ROOT_EVAL    = 8'd136
   } reg_addr_e;

endpackage

`default_nettype wire
